// File: compile.f
+incdir+verilog
verilog/upsize_pkg.sv
verilog/upsize_aw_planner.sv
verilog/upsize_w_sequencer.sv
verilog/upsize_byte_lane.sv
verilog/upsize_beat_packer.sv
verilog/axi_write_upsizer.sv
test/axi_write_upsizer_properties.sv
test/tb_clock_gen.sv
test/tb_axi_write_upsizer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the write upsizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f compile.f \
  --top-module tb_axi_write_upsizer -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

// File: test/tb_axi_write_upsizer.sv
`timescale 1ns/10ps

module tb_axi_write_upsizer;
  import upsize_pkg::*;

  // Narrow beats over all bursts set the watchdog limit
  localparam int total_beats    = 4 + 4 + 4 + 8;
  localparam int timeout_cycles = total_beats * 10 + 200;

  logic         clk_i;
  logic         rst_ni;
  aw_req_t      in_aw;
  logic         in_aw_valid;
  logic         in_aw_ready;
  narrow_w_t    in_w;
  logic         in_w_valid;
  logic         in_w_ready;
  b_rsp_t       in_b;
  logic         in_b_valid;
  logic         in_b_ready;
  aw_req_t      out_aw;
  logic         out_aw_valid;
  logic         out_aw_ready = 1'b1;
  wide_w_t      out_w;
  logic         out_w_valid;
  logic         out_w_ready = 1'b1;
  b_rsp_t       out_b;
  logic         out_b_valid;
  logic         out_b_ready;

  logic         stall = 1'b0;
  int           aw_wait = 0;
  int           cycles = 0;
  int           checks = 0;
  int           errors = 0;
  int           mark = 0;
  int           tests = 0;
  int           failed_tests = 0;
  aw_req_t      exp_aw[$];
  wide_w_t      exp_w[$];
  narrow_data_t w_data[$];

  tb_clock_gen u_clock_gen (.clk_i, .rst_ni);

  axi_write_upsizer UUT (.*);

  bind axi_write_upsizer axi_write_upsizer_properties u_properties (.*);

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  function automatic int total_errors();
    return errors + int'(UUT.u_properties.fail_count);
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_aw(input aw_req_t got);
    aw_req_t exp;
    checks++;
    if (exp_aw.size() == 0) begin
      $display("Downstream address arrived when none was expected");
      errors++;
    end else begin
      exp = exp_aw.pop_front();
      assert (got == exp) else begin
        $display("CHECK FAILED out_aw got %h exp %h", got, exp);
        errors++;
      end
    end
  endtask

  task automatic check_w(input wide_w_t got);
    wide_w_t    exp;
    wide_data_t mask;
    checks++;
    if (exp_w.size() == 0) begin
      $display("Wide beat arrived when none was expected");
      errors++;
    end else begin
      exp = exp_w.pop_front();
      for (int b = 0; b < $bits(wide_strb_t); b++)
        mask[8*b +: 8] = {8{exp.strb[b]}};
      assert (got.strb == exp.strb) else begin
        $display("CHECK FAILED out_w.strb got %h exp %h", got.strb, exp.strb);
        errors++;
      end
      assert (got.last == exp.last) else begin
        $display("CHECK FAILED out_w.last got %h exp %h", got.last, exp.last);
        errors++;
      end
      // Only strobed bytes carry data
      assert ((got.data & mask) == (exp.data & mask)) else begin
        $display("CHECK FAILED out_w.data got %h exp %h", got.data & mask, exp.data & mask);
        errors++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni && out_aw_valid && out_aw_ready) check_aw(out_aw);
    if (rst_ni && out_w_valid && out_w_ready) check_w(out_w);
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timed out after %0d cycles waiting on the DUT", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // Downstream address held off a few cycles and wide ready random while stalling
  always @(negedge clk_i) begin
    if (stall && out_aw_valid) aw_wait++;
    else aw_wait = 0;
    out_aw_ready = !stall || (aw_wait > 2);
    out_w_ready  = stall ? ($urandom_range(0, 1) != 0) : 1'b1;
  end

  // ----------------------------------------------------------
  // Reference model and drivers
  // ----------------------------------------------------------
  task automatic predict_burst(input aw_req_t req);
    aw_req_t      exp;
    wide_w_t      acc;
    addr_t        a;
    addr_t        a_next;
    addr_t        a_end;
    logic         merge;
    int           half;
    narrow_data_t word;
    merge = req.cache[CACHE_MODIFIABLE_BIT] && (req.burst == BURST_INCR);
    exp   = req;
    if (merge) begin
      a_end    = (req.addr & ~addr_t'(3)) + (addr_t'(req.len) << 2);
      exp.len  = len_t'(((a_end & ~addr_t'(7)) - (req.addr & ~addr_t'(7))) >> 3);
      exp.size = 3'd3;
    end
    exp_aw.push_back(exp);
    acc = '0;
    a   = req.addr;
    for (int i = 0; i <= int'(req.len); i++) begin
      word = narrow_data_t'($urandom);
      w_data.push_back(word);
      half = int'(a[2]);
      acc.data[32*half +: 32] = word;
      acc.strb[4*half +: 4]   = 4'hf;
      a_next = (a & ~addr_t'(3)) + addr_t'(4);
      if (!merge || i == int'(req.len) || a_next[31:3] != a[31:3]) begin
        acc.last = (i == int'(req.len));
        exp_w.push_back(acc);
        acc = '0;
      end
      a = a_next;
    end
  endtask

  // Drivers start and end on a falling edge
  task automatic send_aw(input aw_req_t req);
    in_aw       = req;
    in_aw_valid = 1'b1;
    do @(posedge clk_i); while (!in_aw_ready);
    @(negedge clk_i);
    in_aw_valid = 1'b0;
  endtask

  task automatic send_w(input int n);
    for (int i = 0; i < n; i++) begin
      in_w.data  = w_data.pop_front();
      in_w.strb  = 4'hf;
      in_w.last  = (i == n - 1);
      in_w_valid = 1'b1;
      do @(posedge clk_i); while (!in_w_ready);
      @(negedge clk_i);
    end
    in_w_valid = 1'b0;
  endtask

  task automatic run_burst(input addr_t addr, input len_t len, input cache_t cache,
                           input id_t id);
    aw_req_t req;
    req = '{id: id, addr: addr, len: len, size: 3'd2, burst: BURST_INCR, cache: cache};
    predict_burst(req);
    send_aw(req);
    send_w(int'(len) + 1);
    while (exp_w.size() != 0 || exp_aw.size() != 0) @(negedge clk_i);
  endtask

  task automatic drive_responses(input int n);
    for (int i = 0; i < n; i++) begin
      out_b.id    = id_t'($urandom);
      out_b.resp  = resp_t'($urandom);
      out_b_valid = $urandom_range(0, 1) != 0;
      in_b_ready  = $urandom_range(0, 1) != 0;
      @(negedge clk_i);
    end
    out_b_valid = 1'b0;
  endtask

  task automatic report_test(input string name);
    tests++;
    if (total_errors() == mark) begin
      $display("test %-16s ok", name);
    end else begin
      $display("test %-16s %0d errors", name, total_errors() - mark);
      failed_tests++;
    end
    mark = total_errors();
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    void'($urandom(38));
    in_aw        = '0;
    in_aw_valid  = 1'b0;
    in_w         = '0;
    in_w_valid   = 1'b0;
    in_b_ready   = 1'b0;
    out_b        = '0;
    out_b_valid  = 1'b0;

    @(posedge clk_i);
    @(negedge clk_i);
    check_bit("out_aw_valid", out_aw_valid, 1'b0);
    check_bit("out_w_valid", out_w_valid, 1'b0);
    check_bit("in_w_ready", in_w_ready, 1'b0);
    check_bit("in_aw_ready", in_aw_ready, 1'b1);
    wait (rst_ni === 1'b1);
    @(negedge clk_i);
    check_bit("out_aw_valid", out_aw_valid, 1'b0);
    check_bit("out_w_valid", out_w_valid, 1'b0);
    check_bit("in_w_ready", in_w_ready, 1'b0);
    check_bit("in_aw_ready", in_aw_ready, 1'b1);
    report_test("reset values");

    run_burst(32'h0000_1000, 8'd3, 4'b0011, 4'h1);
    report_test("merge aligned");
    run_burst(32'h0000_1004, 8'd3, 4'b0010, 4'h2);
    report_test("merge unaligned");
    run_burst(32'h0000_2004, 8'd3, 4'b0000, 4'h3);
    report_test("passthrough");
    stall = 1'b1;
    run_burst(32'h0000_3004, 8'd7, 4'b0010, 4'h4);
    stall = 1'b0;
    report_test("back-pressure");
    drive_responses(16);
    report_test("response");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, total_errors());
    if (total_errors() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_i,
  output logic rst_ni
);

  // 4 ns period
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Reset held for 4 cycles, released on a falling edge
  initial begin
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

endmodule

// File: test/axi_write_upsizer_properties.sv
`timescale 1ns/10ps

module axi_write_upsizer_properties (
  input logic                  clk_i,
  input logic                  rst_ni,
  input upsize_pkg::aw_req_t   out_aw,
  input logic                  out_aw_valid,
  input logic                  out_aw_ready,
  input logic                  in_w_ready,
  input upsize_pkg::wide_w_t   out_w,
  input logic                  out_w_valid,
  input logic                  out_w_ready,
  input upsize_pkg::b_rsp_t    in_b,
  input logic                  in_b_valid,
  input logic                  in_b_ready,
  input upsize_pkg::b_rsp_t    out_b,
  input logic                  out_b_valid,
  input logic                  out_b_ready
);

  int unsigned fail_count = 0;

  // ----------------------------------------------------------
  // Reset and handshake stability
  // ----------------------------------------------------------
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> !out_aw_valid && !out_w_valid && !in_w_ready)
    else begin
      $error("Downstream valid or upstream w ready active during reset");
      fail_count++;
    end

  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_aw_valid && !out_aw_ready |=> out_aw_valid && $stable(out_aw))
    else begin
      $error("Downstream address changed or dropped while stalled");
      fail_count++;
    end

  a_w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_w_valid && !out_w_ready |=> out_w_valid && $stable(out_w))
    else begin
      $error("Wide beat changed or dropped while stalled");
      fail_count++;
    end

  // Narrow side must be held off while the wide beat waits
  a_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_w_valid && !out_w_ready |-> !in_w_ready)
    else begin
      $error("Upstream w ready high while the wide beat is held");
      fail_count++;
    end

  // ----------------------------------------------------------
  // Write response passthrough
  // ----------------------------------------------------------
  a_b_forward: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_b_valid == out_b_valid && in_b == out_b)
    else begin
      $error("Upstream b channel differs from downstream b channel");
      fail_count++;
    end

  a_b_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_b_ready == in_b_ready)
    else begin
      $error("Downstream b ready differs from upstream b ready");
      fail_count++;
    end

endmodule

// File: verilog/axi_write_upsizer.sv
`timescale 1ns/10ps
`include "upsize_cfg.svh"

module axi_write_upsizer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Narrow side
  input  upsize_pkg::aw_req_t   in_aw,
  input  logic                  in_aw_valid,
  output logic                  in_aw_ready,
  input  upsize_pkg::narrow_w_t in_w,
  input  logic                  in_w_valid,
  output logic                  in_w_ready,
  output upsize_pkg::b_rsp_t    in_b,
  output logic                  in_b_valid,
  input  logic                  in_b_ready,
  // Wide side
  output upsize_pkg::aw_req_t   out_aw,
  output logic                  out_aw_valid,
  input  logic                  out_aw_ready,
  output upsize_pkg::wide_w_t   out_w,
  output logic                  out_w_valid,
  input  logic                  out_w_ready,
  input  upsize_pkg::b_rsp_t    out_b,
  input  logic                  out_b_valid,
  output logic                  out_b_ready
);
  import upsize_pkg::*;

  burst_plan_t plan;
  logic        plan_start;
  logic        burst_done;
  logic        capture;
  logic        flush;
  logic        flush_last;
  logic        drain;
  logic        packer_space;
  addr_t       lane_offset;
  size_t       beat_size;
  wide_data_t  lane_bytes;
  wide_strb_t  lane_strbs;

  upsize_aw_planner u_planner (
    .clk_i, .rst_ni, .in_aw, .in_aw_valid, .in_aw_ready,
    .out_aw, .out_aw_valid, .out_aw_ready, .plan, .plan_start, .burst_done
  );

  upsize_w_sequencer u_sequencer (
    .clk_i, .rst_ni, .plan, .plan_start, .in_w_valid, .in_w_last(in_w.last),
    .in_w_ready, .packer_space, .capture, .lane_offset, .beat_size,
    .flush, .flush_last, .burst_done, .drain
  );

  // One lane per wide byte
  for (genvar i = 0; i < `UPS_WIDE_BYTES; i++) begin : g_lane
    upsize_byte_lane #(.LANE_INDEX(i)) u_lane (
      .clk_i, .rst_ni, .capture, .drain, .lane_offset, .beat_size,
      .narrow_data(in_w.data), .narrow_strb(in_w.strb),
      .lane_byte(lane_bytes[8*i +: 8]), .lane_strb(lane_strbs[i])
    );
  end

  upsize_beat_packer u_packer (
    .clk_i, .rst_ni, .lane_bytes, .lane_strbs, .flush, .flush_last,
    .out_w, .out_w_valid, .out_w_ready, .drain, .packer_space
  );

  // Write response goes straight back
  assign in_b        = out_b;
  assign in_b_valid  = out_b_valid;
  assign out_b_ready = in_b_ready;

endmodule

// File: verilog/upsize_beat_packer.sv
`timescale 1ns/10ps

module upsize_beat_packer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  upsize_pkg::wide_data_t lane_bytes,
  input  upsize_pkg::wide_strb_t lane_strbs,
  input  logic                   flush,
  input  logic                   flush_last,
  output upsize_pkg::wide_w_t    out_w,
  output logic                   out_w_valid,
  input  logic                   out_w_ready,
  output logic                   drain,
  output logic                   packer_space
);

  logic valid_q;
  logic last_q;

  // ----------------------------------------------------------
  // Outgoing wide beat
  // ----------------------------------------------------------

  // Lane registers already hold the beat, only valid and last live here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b1;
      last_q  <= flush_last;
    end else if (drain) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end
  end

  assign out_w.data  = lane_bytes;
  assign out_w.strb  = lane_strbs;
  assign out_w.last  = last_q;
  assign out_w_valid = valid_q;

  // Handshake on the wide side
  assign drain        = valid_q && out_w_ready;
  // Room for a narrow beat when empty or emptying this cycle
  assign packer_space = !valid_q || out_w_ready;

endmodule

// File: verilog/upsize_byte_lane.sv
`timescale 1ns/10ps
`include "upsize_cfg.svh"

module upsize_byte_lane #(
  parameter int LANE_INDEX = 0
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     capture,
  input  logic                     drain,
  input  upsize_pkg::addr_t        lane_offset,
  input  upsize_pkg::size_t        beat_size,
  input  upsize_pkg::narrow_data_t narrow_data,
  input  upsize_pkg::narrow_strb_t narrow_strb,
  output upsize_pkg::lane_byte_t   lane_byte,
  output logic                     lane_strb
);

  localparam int WideOffW   = $clog2(`UPS_WIDE_BYTES);
  localparam int NarrowOffW = $clog2(`UPS_NARROW_BYTES);

  int                    wide_off;
  int                    narrow_off;
  int                    src_idx;
  logic [NarrowOffW-1:0] src_byte;
  logic                  selected;

  // Steering: lane inside the size window, source shifted by narrow offset
  always_comb begin
    wide_off   = int'(lane_offset[WideOffW-1:0]);
    narrow_off = int'(lane_offset[NarrowOffW-1:0]);
    src_idx    = LANE_INDEX + narrow_off - wide_off;
    src_byte   = src_idx[NarrowOffW-1:0];
    selected   = (LANE_INDEX >= wide_off) &&
                 (LANE_INDEX - wide_off < (1 << beat_size)) &&
                 (src_idx < `UPS_NARROW_BYTES);
  end

  always_ff @(posedge clk_i) begin
    if (capture && selected) lane_byte <= narrow_data[8*src_byte +: 8];
  end

  // A new capture overrides the clear from a drain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_strb <= 1'b0;
    end else if (capture && selected) begin
      lane_strb <= narrow_strb[src_byte];
    end else if (drain) begin
      lane_strb <= 1'b0;
    end
  end

endmodule

// File: verilog/upsize_w_sequencer.sv
`timescale 1ns/10ps
`include "upsize_cfg.svh"

module upsize_w_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  upsize_pkg::burst_plan_t plan,
  input  logic                    plan_start,
  input  logic                    in_w_valid,
  input  logic                    in_w_last,
  output logic                    in_w_ready,
  input  logic                    packer_space,
  output logic                    capture,
  output upsize_pkg::addr_t       lane_offset,
  output upsize_pkg::size_t       beat_size,
  output logic                    flush,
  output logic                    flush_last,
  output logic                    burst_done,
  input  logic                    drain
);
  import upsize_pkg::*;

  localparam addr_t WideMask = addr_t'(`UPS_WIDE_BYTES - 1);

  seq_state_e state_q;
  addr_t      addr_q;
  len_t       left_q;
  size_t      size_q;
  logic       tail_q;
  addr_t      size_mask;
  addr_t      addr_next;
  logic       beat_last;
  logic       word_end;

  always_comb begin
    size_mask = (addr_t'(1) << size_q) - addr_t'(1);
    addr_next = (addr_q & ~size_mask) + (addr_t'(1) << size_q);
    beat_last = (left_q == '0) || in_w_last;
    // Next narrow beat lands in another wide word
    word_end  = (addr_next & ~WideMask) != (addr_q & ~WideMask);
  end

  // Stop taking beats once the last one sits in the packer
  assign in_w_ready  = (state_q != IDLE) && !tail_q && packer_space;
  assign capture     = in_w_valid && in_w_ready;
  assign lane_offset = addr_q;
  assign beat_size   = size_q;
  assign flush       = capture && ((state_q == PASS) || beat_last || word_end);
  assign flush_last  = capture && beat_last;
  assign burst_done  = tail_q && drain;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
      left_q  <= '0;
      size_q  <= '0;
      tail_q  <= 1'b0;
    end else begin
      if (plan_start) begin
        state_q <= plan.merge ? MERGE : PASS;
        addr_q  <= plan.start_addr;
        left_q  <= plan.narrow_len;
        size_q  <= plan.narrow_size;
      end
      if (capture) begin
        addr_q <= addr_next;
        left_q <= left_q - len_t'(1);
        if (beat_last) tail_q <= 1'b1;
      end
      if (burst_done) begin
        state_q <= IDLE;
        tail_q  <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/upsize_aw_planner.sv
`timescale 1ns/10ps
`include "upsize_cfg.svh"

module upsize_aw_planner (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  upsize_pkg::aw_req_t     in_aw,
  input  logic                    in_aw_valid,
  output logic                    in_aw_ready,
  output upsize_pkg::aw_req_t     out_aw,
  output logic                    out_aw_valid,
  input  logic                    out_aw_ready,
  output upsize_pkg::burst_plan_t plan,
  output logic                    plan_start,
  input  logic                    burst_done
);
  import upsize_pkg::*;

  localparam int unsigned WideShift = $clog2(`UPS_WIDE_BYTES);
  localparam addr_t       WideMask  = addr_t'(`UPS_WIDE_BYTES - 1);

  typedef enum logic [1:0] {
    PLAN_IDLE,
    PLAN_ADDR,
    PLAN_BUSY
  } plan_state_e;

  plan_state_e state_q;
  aw_req_t     aw_q;
  aw_req_t     aw_d;
  burst_plan_t plan_q;
  logic        merge;
  addr_t       size_mask;
  addr_t       addr_first;
  addr_t       addr_last;

  // Mode rule, INCR with modifiable cache gets merged to full wide beats
  always_comb begin
    merge      = in_aw.cache[CACHE_MODIFIABLE_BIT] && (in_aw.burst == BURST_INCR);
    size_mask  = (addr_t'(1) << in_aw.size) - addr_t'(1);
    addr_first = in_aw.addr & ~WideMask;
    // Wide word holding the final narrow beat
    addr_last  = ((in_aw.addr & ~size_mask) + (addr_t'(in_aw.len) << in_aw.size)) & ~WideMask;
    aw_d       = in_aw;
    if (merge) begin
      aw_d.len  = len_t'((addr_last - addr_first) >> WideShift);
      aw_d.size = size_t'(WideShift);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PLAN_IDLE;
    end else begin
      case (state_q)
        PLAN_IDLE: if (in_aw_valid) state_q <= PLAN_ADDR;
        PLAN_ADDR: if (out_aw_ready) state_q <= PLAN_BUSY;
        PLAN_BUSY: if (burst_done) state_q <= PLAN_IDLE;
        default:   state_q <= PLAN_IDLE;
      endcase
    end
  end

  // Request payload, loaded once per burst
  always_ff @(posedge clk_i) begin
    if (in_aw_valid && in_aw_ready) begin
      aw_q                <= aw_d;
      plan_q.start_addr   <= in_aw.addr;
      plan_q.narrow_len   <= in_aw.len;
      plan_q.narrow_size  <= in_aw.size;
      plan_q.merge        <= merge;
    end
  end

  assign in_aw_ready  = (state_q == PLAN_IDLE);
  assign out_aw       = aw_q;
  assign out_aw_valid = (state_q == PLAN_ADDR);
  assign plan         = plan_q;
  assign plan_start   = out_aw_valid && out_aw_ready;

endmodule

// File: verilog/upsize_pkg.sv
`include "upsize_cfg.svh"

package upsize_pkg;

  // ----------------------------------------------------------
  // Field types
  // ----------------------------------------------------------
  typedef logic [`UPS_ADDR_WIDTH-1:0]       addr_t;
  typedef logic [7:0]                       len_t;
  typedef logic [2:0]                       size_t;
  typedef logic [1:0]                       burst_t;
  typedef logic [3:0]                       cache_t;
  typedef logic [`UPS_ID_WIDTH-1:0]         id_t;
  typedef logic [1:0]                       resp_t;
  typedef logic [7:0]                       lane_byte_t;
  typedef logic [8*`UPS_NARROW_BYTES-1:0]   narrow_data_t;
  typedef logic [8*`UPS_WIDE_BYTES-1:0]     wide_data_t;
  typedef logic [`UPS_NARROW_BYTES-1:0]     narrow_strb_t;
  typedef logic [`UPS_WIDE_BYTES-1:0]       wide_strb_t;

  // Burst type codes
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  // Bufferable is bit 0, modifiable is bit 1
  localparam int unsigned CACHE_MODIFIABLE_BIT = 1;

  // ----------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } aw_req_t;

  typedef struct packed {
    narrow_data_t data;
    narrow_strb_t strb;
    logic         last;
  } narrow_w_t;

  typedef struct packed {
    wide_data_t data;
    wide_strb_t strb;
    logic       last;
  } wide_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_rsp_t;

  // Handed from the address planner to the write sequencer
  typedef struct packed {
    addr_t start_addr;
    len_t  narrow_len;
    size_t narrow_size;
    logic  merge;
  } burst_plan_t;

  typedef enum logic [1:0] {
    IDLE,
    PASS,
    MERGE
  } seq_state_e;

endpackage

// File: verilog/upsize_cfg.svh
`ifndef UPSIZE_CFG_SVH
`define UPSIZE_CFG_SVH

// Bus geometry of the write upsizer

// Byte address width, same on both sides
`define UPS_ADDR_WIDTH 32
// Bytes per beat on the narrow and the wide bus
`define UPS_NARROW_BYTES 4
`define UPS_WIDE_BYTES 8
// Transaction ID width
`define UPS_ID_WIDTH 4

`endif
